// File: build.f
src/orbPkg.sv
src/uartRx.sv
src/chanBuffer.sv
src/orbPacker.sv
src/frameBank.sv
src/frameSender.sv
src/orbTop.sv
testbench/orbTop_tb.sv

// File: src/chanBuffer.sv
`timescale 1ns/1ps
`default_nettype none

module chanBuffer
(
	input wire clk100MHz,
	input wire rstN,
	input wire rxValid,
	input wire [orbPkg::byteBits-1:0] rxByte,
	input wire rdEn,
	input wire [orbPkg::idxBits-1:0] rdIdx,
	input wire rdRelease,
	output logic [orbPkg::byteBits-1:0] rdByte,
	output logic full,
	output logic overflow
);

	logic [orbPkg::byteBits-1:0] mem [orbPkg::burstBytes];
	logic [orbPkg::idxBits-1:0] count;
	logic store;

	assign store = rxValid && !full;

	always_ff @(posedge clk100MHz or negedge rstN)
	begin
		if (!rstN)
		begin
			count <= '0;
			full <= 1'b0;
			overflow <= 1'b0;
		end
		else
		begin
			if (rdRelease)
			begin
				count <= '0;
				full <= 1'b0;
			end
			else if (store)
			begin
				count <= count + 1'b1; // wraps back to 0 on the last byte
				if (count == orbPkg::burstBytes - 1)
					full <= 1'b1;
			end
			if (rxValid && full)
				overflow <= 1'b1; // sticky, byte is lost
		end
	end

	always_ff @(posedge clk100MHz)
	begin
		if (store)
			mem[count] <= rxByte;
		if (rdEn)
			rdByte <= mem[rdIdx]; // one clock read latency
	end

	releaseWhenFull: assert property (@(posedge clk100MHz) disable iff (!rstN)
		rdRelease |-> full);

endmodule

`default_nettype wire

// File: src/frameBank.sv
`timescale 1ns/1ps
`default_nettype none

module frameBank
(
	input wire clk100MHz,
	input wire rstN,
	input wire wrEn,
	input wire [orbPkg::wordBits-1:0] wrWord,
	input wire [orbPkg::addrBits-1:0] rdAddr,
	input wire frameDone,
	output logic fillReady,
	output logic bankFull,
	output logic [orbPkg::wordBits-1:0] rdWord
);

	logic [orbPkg::wordBits-1:0] mem [2][orbPkg::frameWords];
	logic fillSel; // bank on the fill side
	logic fillDone;
	logic [orbPkg::addrBits-1:0] fillPtr;

	assign fillReady = !fillDone;

	always_ff @(posedge clk100MHz or negedge rstN)
	begin
		if (!rstN)
		begin
			fillSel <= 1'b0;
			fillDone <= 1'b0;
			fillPtr <= '0;
			bankFull <= 1'b0;
		end
		else
		begin
			if (wrEn)
			begin
				fillPtr <= fillPtr + 1'b1;
				if (fillPtr == orbPkg::frameWords - 1)
					fillDone <= 1'b1;
			end
			if (frameDone)
				bankFull <= 1'b0; // drain side free again
			else if (fillDone && !bankFull)
			begin
				fillSel <= ~fillSel; // swap roles
				fillDone <= 1'b0;
				bankFull <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk100MHz)
	begin
		if (wrEn)
			mem[fillSel][fillPtr] <= wrWord;
		rdWord <= mem[~fillSel][rdAddr];
	end

	noWriteWhenBlocked: assert property (@(posedge clk100MHz) disable iff (!rstN)
		wrEn |-> fillReady);

endmodule

`default_nettype wire

// File: src/frameSender.sv
`timescale 1ns/1ps
`default_nettype none

module frameSender
(
	input wire clk100MHz,
	input wire rstN,
	input wire bankFull,
	input wire [orbPkg::wordBits-1:0] rdWord,
	input wire frameAck,
	output logic [orbPkg::addrBits-1:0] rdAddr,
	output logic frameDone,
	output logic frameReq,
	output logic [orbPkg::wordBits-1:0] frameWord,
	output logic frameFirst
);

	typedef enum logic [2:0] {sIdle, sFetch, sRaise, sWaitHi, sWaitLo} stateType;

	stateType state;
	logic lastWord;

	assign lastWord = (rdAddr == orbPkg::frameWords - 1);
	assign frameDone = (state == sWaitLo) && !frameAck && lastWord;

	always_ff @(posedge clk100MHz or negedge rstN)
	begin
		if (!rstN)
		begin
			state <= sIdle;
			rdAddr <= '0;
			frameReq <= 1'b0;
			frameFirst <= 1'b0;
		end
		else
		begin
			case (state)
				sIdle:
					if (bankFull)
						state <= sFetch;
				sFetch:
					state <= sRaise; // memory read in flight
				sRaise:
				begin
					frameReq <= 1'b1;
					frameFirst <= (rdAddr == '0);
					state <= sWaitHi;
				end
				sWaitHi:
					if (frameAck)
					begin
						frameReq <= 1'b0;
						state <= sWaitLo;
					end
				sWaitLo:
					if (!frameAck)
					begin
						rdAddr <= rdAddr + 1'b1; // wraps to word 0 after the frame
						state <= lastWord ? sIdle : sFetch;
					end
				default: state <= sIdle;
			endcase
		end
	end

	always_ff @(posedge clk100MHz)
	begin
		if (state == sRaise)
			frameWord <= rdWord;
	end

	wordStable: assert property (@(posedge clk100MHz) disable iff (!rstN)
		frameReq && $past(frameReq) |-> $stable(frameWord));

endmodule

`default_nettype wire

// File: src/orbPacker.sv
`timescale 1ns/1ps
`default_nettype none

module orbPacker
(
	input wire clk100MHz,
	input wire rstN,
	input wire [orbPkg::numChans-1:0] full,
	input wire [orbPkg::numChans*orbPkg::byteBits-1:0] rdByte,
	input wire fillReady,
	output logic [orbPkg::numChans-1:0] rdEn,
	output logic [orbPkg::idxBits-1:0] rdIdx,
	output logic [orbPkg::numChans-1:0] rdRelease,
	output logic wrEn,
	output logic [orbPkg::wordBits-1:0] wrWord
);

	logic busy;
	logic [orbPkg::chanBits-1:0] chan; // granted channel
	logic [orbPkg::idxBits-1:0] idx;
	logic [orbPkg::chanBits-1:0] pick;
	logic anyFull;
	logic lastRead;
	logic wrFirst;
	logic [orbPkg::chanBits-1:0] wrChan;

	// fixed priority, lowest index wins
	always_comb
	begin
		pick = '0;
		anyFull = 1'b0;
		for (int i = orbPkg::numChans - 1; i >= 0; i--)
		begin
			if (full[i])
			begin
				pick = i[orbPkg::chanBits-1:0];
				anyFull = 1'b1;
			end
		end
	end

	assign lastRead = busy && (idx == orbPkg::burstBytes - 1);
	assign rdIdx = idx;

	always_comb
	begin
		rdEn = '0;
		rdRelease = '0;
		if (busy)
			rdEn[chan] = 1'b1;
		if (lastRead)
			rdRelease[chan] = 1'b1; // buffer may refill from here
	end

	always_ff @(posedge clk100MHz or negedge rstN)
	begin
		if (!rstN)
		begin
			busy <= 1'b0;
			chan <= '0;
			idx <= '0;
			wrEn <= 1'b0;
			wrFirst <= 1'b0;
			wrChan <= '0;
		end
		else
		begin
			wrEn <= busy; // read data lands one clock later
			wrFirst <= busy && (idx == '0);
			wrChan <= chan;
			if (!busy)
			begin
				// hold off until the last word of a burst is in the bank
				if (anyFull && fillReady && !wrEn)
				begin
					busy <= 1'b1;
					chan <= pick;
					idx <= '0;
				end
			end
			else
			begin
				idx <= idx + 1'b1;
				if (lastRead)
					busy <= 1'b0;
			end
		end
	end

	// tag the byte with its channel
	always_comb
	begin
		wrWord[orbPkg::wordBits-1:orbPkg::chanLsb] = wrChan;
		wrWord[orbPkg::startBit] = wrFirst;
		wrWord[orbPkg::byteBits-1:0] = rdByte[wrChan*orbPkg::byteBits +: orbPkg::byteBits];
	end

	oneReader: assert property (@(posedge clk100MHz) disable iff (!rstN)
		$onehot0(rdEn));

endmodule

`default_nettype wire

// File: src/orbPkg.sv
`default_nettype none

package orbPkg;

	localparam int numChans = 5; // serial channels
	localparam int chanBits = 3;
	localparam int burstBytes = 4; // bytes per burst
	localparam int idxBits = $clog2(burstBytes);
	localparam int byteBits = 8;
	localparam int wordBits = 12; // orbit word
	localparam int frameWords = 16; // always four bursts
	localparam int addrBits = 4;
	localparam int bitCycles = 16; // clocks per serial bit

	// word layout, msb first: channel, burst-start flag, byte
	localparam int startBit = byteBits;
	localparam int chanLsb = byteBits + 1;

endpackage

`default_nettype wire

// File: src/orbTop.sv
`timescale 1ns/1ps
`default_nettype none

module orbTop
(
	input wire clk100MHz,
	input wire rstN,
	input wire [orbPkg::numChans-1:0] rx,
	output wire frameReq,
	output wire [orbPkg::wordBits-1:0] frameWord,
	output wire frameFirst,
	output wire [orbPkg::numChans-1:0] overflow,
	input wire frameAck
);

	logic [orbPkg::numChans-1:0] rxValid;
	logic [orbPkg::numChans*orbPkg::byteBits-1:0] rxByte;
	logic [orbPkg::numChans*orbPkg::byteBits-1:0] rdByte;
	logic [orbPkg::numChans-1:0] full;
	logic [orbPkg::numChans-1:0] rdEn;
	logic [orbPkg::numChans-1:0] rdRelease;
	logic [orbPkg::idxBits-1:0] rdIdx;
	logic wrEn;
	logic [orbPkg::wordBits-1:0] wrWord;
	logic fillReady;
	logic bankFull;
	logic [orbPkg::wordBits-1:0] rdWord;
	logic [orbPkg::addrBits-1:0] rdAddr;
	logic frameDone;

	genvar ch;
	generate
		for (ch = 0; ch < orbPkg::numChans; ch++)
		begin : chanGen
			uartRx uartRx_i (
				.clk100MHz(clk100MHz),
				.rstN(rstN),
				.rx(rx[ch]),
				.rxValid(rxValid[ch]),
				.rxByte(rxByte[ch*orbPkg::byteBits +: orbPkg::byteBits])
			);

			chanBuffer chanBuffer_i (
				.clk100MHz(clk100MHz),
				.rstN(rstN),
				.rxValid(rxValid[ch]),
				.rxByte(rxByte[ch*orbPkg::byteBits +: orbPkg::byteBits]),
				.rdEn(rdEn[ch]),
				.rdIdx(rdIdx), // shared, only one rdEn is ever high
				.rdRelease(rdRelease[ch]),
				.rdByte(rdByte[ch*orbPkg::byteBits +: orbPkg::byteBits]),
				.full(full[ch]),
				.overflow(overflow[ch])
			);
		end
	endgenerate

	orbPacker orbPacker_i (
		.clk100MHz(clk100MHz),
		.rstN(rstN),
		.full(full),
		.rdByte(rdByte),
		.fillReady(fillReady),
		.rdEn(rdEn),
		.rdIdx(rdIdx),
		.rdRelease(rdRelease),
		.wrEn(wrEn),
		.wrWord(wrWord)
	);

	frameBank frameBank_i (
		.clk100MHz(clk100MHz),
		.rstN(rstN),
		.wrEn(wrEn),
		.wrWord(wrWord),
		.rdAddr(rdAddr),
		.frameDone(frameDone),
		.fillReady(fillReady),
		.bankFull(bankFull),
		.rdWord(rdWord)
	);

	frameSender frameSender_i (
		.clk100MHz(clk100MHz),
		.rstN(rstN),
		.bankFull(bankFull),
		.rdWord(rdWord),
		.frameAck(frameAck),
		.rdAddr(rdAddr),
		.frameDone(frameDone),
		.frameReq(frameReq),
		.frameWord(frameWord),
		.frameFirst(frameFirst)
	);

endmodule

`default_nettype wire

// File: src/uartRx.sv
`timescale 1ns/1ps
`default_nettype none

module uartRx
(
	input wire clk100MHz,
	input wire rstN,
	input wire rx,
	output logic rxValid,
	output logic [orbPkg::byteBits-1:0] rxByte
);

	localparam int cntBits = $clog2(orbPkg::bitCycles);
	localparam int bitBits = $clog2(orbPkg::byteBits);

	typedef enum logic [1:0] {sIdle, sStart, sData, sStop} stateType;

	stateType state;
	logic [1:0] rxSync;
	logic rxS;
	logic [cntBits-1:0] cnt;
	logic [bitBits-1:0] bitIdx;
	logic bitEnd;

	assign rxS = rxSync[1];
	assign bitEnd = (cnt == orbPkg::bitCycles - 1);

	always_ff @(posedge clk100MHz or negedge rstN)
	begin
		if (!rstN)
			rxSync <= 2'b11; // line idles high
		else
			rxSync <= {rxSync[0], rx};
	end

	always_ff @(posedge clk100MHz or negedge rstN)
	begin
		if (!rstN)
		begin
			state <= sIdle;
			cnt <= '0;
			bitIdx <= '0;
			rxValid <= 1'b0;
		end
		else
		begin
			rxValid <= 1'b0;
			case (state)
				sIdle:
				begin
					cnt <= '0;
					if (!rxS)
						state <= sStart; // falling edge of start bit
				end
				sStart:
				begin
					if (cnt == orbPkg::bitCycles / 2 - 1)
					begin
						cnt <= '0;
						bitIdx <= '0;
						state <= rxS ? sIdle : sData; // short glitch, not a start
					end
					else
						cnt <= cnt + 1'b1;
				end
				sData:
				begin
					cnt <= bitEnd ? '0 : cnt + 1'b1;
					if (bitEnd)
					begin
						bitIdx <= bitIdx + 1'b1;
						if (bitIdx == orbPkg::byteBits - 1)
							state <= sStop;
					end
				end
				sStop:
				begin
					cnt <= bitEnd ? '0 : cnt + 1'b1;
					if (bitEnd)
					begin
						rxValid <= rxS; // low stop bit drops the byte
						state <= sIdle;
					end
				end
				default: state <= sIdle;
			endcase
		end
	end

	// sampled mid-bit, lsb first
	always_ff @(posedge clk100MHz)
	begin
		if (state == sData && bitEnd)
			rxByte <= {rxS, rxByte[orbPkg::byteBits-1:1]};
	end

	singleStrobe: assert property (@(posedge clk100MHz) disable iff (!rstN)
		rxValid |=> !rxValid);

endmodule

`default_nettype wire

// File: testbench/orbTestdata.txt
// each record holds a channel, a byte and a stop-bit-good flag
// channel 8 waits for a word count and then stalls the consumer while channel 9 releases it
// channel f ends the stimulus
0 11 1 0 12 1 0 13 1 0 14 1
1 21 1 1 22 1 1 ee 0 1 23 1 1 24 1
2 31 1 2 32 1 2 33 1 2 34 1
3 41 1 3 42 1 3 43 1 3 44 1
8 10 0
4 a1 1 4 a2 1 4 a3 1 4 a4 1
3 b1 1 3 b2 1 3 b3 1 3 b4 1
0 c1 1 0 c2 1 0 c3 1 0 c4 1
2 d1 1 2 d2 1 2 d3 1 2 d4 1
1 e1 1 1 e2 1 1 e3 1 1 e4 1
4 f1 1 4 f2 1 4 f3 1 4 f4 1
0 51 1 0 52 1 0 53 1 0 54 1
3 61 1 3 62 1 3 63 1 3 64 1
4 71 1 4 72 1 4 73 1 4 74 1
2 81 1 2 82 1 2 83 1 2 84 1
4 99 1
9 00 0
1 91 1 1 92 1 1 93 1 1 94 1
0 a5 1 0 a6 1 0 a7 1 0 a8 1
f 00 0
@100
// overflow mask and then the expected frame words in output order
010
111 012 013 014 321 222 223 224
531 432 433 434 741 642 643 644
9a1 8a2 8a3 8a4 7b1 6b2 6b3 6b4
1c1 0c2 0c3 0c4 5d1 4d2 4d3 4d4
3e1 2e2 2e3 2e4 9f1 8f2 8f3 8f4
151 052 053 054 761 662 663 664
581 482 483 484 971 872 873 874
391 292 293 294 1a5 0a6 0a7 0a8
fff

// File: testbench/orbTop_tb.sv
`timescale 1ns/1ps
`default_nettype none

module orbTop_tb;

	localparam int memDepth = 512;
	localparam int expBase = 256; // overflow mask, then expected words
	localparam int marginCycles = 20000;

	logic clk100MHz = 1'b0;
	logic rstN;
	logic [orbPkg::numChans-1:0] rx;
	logic frameAck;
	wire frameReq;
	wire [orbPkg::wordBits-1:0] frameWord;
	wire frameFirst;
	wire [orbPkg::numChans-1:0] overflow;

	logic [orbPkg::wordBits-1:0] testMem [0:memDepth-1];
	logic [orbPkg::wordBits-1:0] gotWord;
	logic gotFirst;
	logic [orbPkg::chanBits-1:0] burstChan;
	logic [3:0] cmd;
	logic holdAck; // consumer stalls while set
	integer seed;
	int errorCount;
	int wordCount;
	int expCount;
	int numBytes;
	int watchCycles;
	int ackDelay;
	int p;

	orbTop orbTop_i (
		.clk100MHz(clk100MHz),
		.rstN(rstN),
		.rx(rx),
		.frameReq(frameReq),
		.frameWord(frameWord),
		.frameFirst(frameFirst),
		.overflow(overflow),
		.frameAck(frameAck)
	);

	always #5 clk100MHz = ~clk100MHz;

	// 8N1 byte, lsb first, then one idle bit
	task automatic sendByte(input int ch, input logic [7:0] data, input logic stopGood);
		rx[ch] = 1'b0;
		repeat (orbPkg::bitCycles) @(negedge clk100MHz);
		for (int i = 0; i < orbPkg::byteBits; i++)
		begin
			rx[ch] = data[i];
			repeat (orbPkg::bitCycles) @(negedge clk100MHz);
		end
		rx[ch] = stopGood;
		repeat (orbPkg::bitCycles) @(negedge clk100MHz);
		rx[ch] = 1'b1;
		repeat (orbPkg::bitCycles) @(negedge clk100MHz);
	endtask

	task automatic checkWord(input logic [orbPkg::wordBits-1:0] word, input logic first);
		logic [orbPkg::wordBits-1:0] expWord;
		logic burstStart;
		burstStart = (wordCount % orbPkg::burstBytes == 0);
		if (wordCount >= expCount)
		begin
			$display("extra word %h arrived after all expected words at %0t", word, $time);
			errorCount++;
		end
		else
		begin
			expWord = testMem[expBase + 1 + wordCount];
			if (word !== expWord)
			begin
				$display("ERROR %0t: word %0d is %h, expected %h", $time, wordCount, word, expWord);
				errorCount++;
			end
			if (first !== (wordCount % orbPkg::frameWords == 0))
			begin
				$display("ERROR %0t: frameFirst is %b on word %0d", $time, first, wordCount);
				errorCount++;
			end
			if (word[orbPkg::startBit] !== burstStart)
			begin
				$display("ERROR %0t: start flag is %b on word %0d", $time,
					word[orbPkg::startBit], wordCount);
				errorCount++;
			end
			if (burstStart)
				burstChan = word[orbPkg::wordBits-1:orbPkg::chanLsb];
			else if (word[orbPkg::wordBits-1:orbPkg::chanLsb] !== burstChan)
			begin
				$display("ERROR %0t: channel changes inside the burst at word %0d", $time,
					wordCount);
				errorCount++;
			end
		end
		wordCount++;
	endtask

	// handshake consumer with random ack delays
	initial
	begin
		@(posedge rstN);
		forever
		begin
			@(negedge clk100MHz);
			if (frameReq && !holdAck)
			begin
				gotWord = frameWord;
				gotFirst = frameFirst;
				ackDelay = $random(seed) & 7;
				repeat (ackDelay) @(negedge clk100MHz);
				frameAck = 1'b1;
				while (frameReq)
					@(negedge clk100MHz);
				ackDelay = $random(seed) & 7;
				repeat (ackDelay) @(negedge clk100MHz);
				frameAck = 1'b0;
				checkWord(gotWord, gotFirst);
			end
		end
	end

	initial
	begin
		wait (watchCycles > 0);
		repeat (watchCycles) @(posedge clk100MHz);
		$display("timeout after %0d clocks with %0d of %0d words received", watchCycles,
			wordCount, expCount);
		$display("TESTBENCH FAILED");
		$finish;
	end

	initial
	begin
		rstN = 1'b0;
		rx = '1; // lines idle high
		frameAck = 1'b0;
		holdAck = 1'b0;
		seed = 32'h8dac;
		errorCount = 0;
		wordCount = 0;
		burstChan = '0;
		$readmemh("testbench/orbTestdata.txt", testMem);

		p = 0;
		numBytes = 0;
		while (p < expBase && testMem[p][3:0] != 4'hf)
		begin
			if (testMem[p] < orbPkg::numChans)
				numBytes++;
			p += 3;
		end
		expCount = 0;
		while (expCount < expBase - 1 && testMem[expBase + 1 + expCount] !== 12'hfff)
			expCount++;
		watchCycles = numBytes * 11 * orbPkg::bitCycles * 2 + marginCycles;

		repeat (8) @(negedge clk100MHz);
		if (frameReq !== 1'b0 || frameFirst !== 1'b0 || overflow !== '0)
		begin
			$display("ERROR %0t: outputs not low in reset, req %b first %b overflow %b",
				$time, frameReq, frameFirst, overflow);
			errorCount++;
		end
		rstN = 1'b1;
		repeat (4) @(negedge clk100MHz);

		p = 0;
		while (testMem[p][3:0] != 4'hf)
		begin
			cmd = testMem[p][3:0];
			if (cmd < orbPkg::numChans)
				sendByte(cmd, testMem[p+1][7:0], testMem[p+2][0]);
			else if (cmd == 4'h8)
			begin
				wait (wordCount >= testMem[p+1]);
				holdAck = 1'b1; // both banks will fill
			end
			else if (cmd == 4'h9)
				holdAck = 1'b0;
			p += 3;
		end

		wait (wordCount >= expCount);
		repeat (500) @(negedge clk100MHz); // catch repeated words
		if (overflow !== testMem[expBase][orbPkg::numChans-1:0])
		begin
			$display("ERROR %0t: overflow is %b, expected %b", $time, overflow,
				testMem[expBase][orbPkg::numChans-1:0]);
			errorCount++;
		end

		$display("errors: %0d, words received: %0d of %0d", errorCount, wordCount, expCount);
		if (errorCount == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

`default_nettype wire
